//--- Makefile
TOP := tb_dcache_test

.PHONY: all lint sim clean

all: sim

# Static checks over the whole project
lint:
	verilator --lint-only --timing -Wno-fatal -f project.f --top-module $(TOP)

# Build and run, pass only when the pass line shows up
sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- project.f
+incdir+verilog
verilog/dcache_test_pkg.sv
verilog/pattern_rom.sv
verilog/mem_tester.sv
verilog/mem_port_arbiter.sv
verilog/data_mem_model.sv
verilog/dcache_test_top.sv
testbench/dcache_test_sva.sv
testbench/tb_dcache_test.sv

//--- testbench/dcache_test_sva.sv
module dcache_test_sva #(
	parameter int LANES = 4
)
(
	input  logic clk,
	input  logic rst,
	input  logic [LANES-1:0] req_valid,
	input  logic [LANES-1:0] ready,
	input  logic [$clog2(LANES)-1:0] grant,
	input  logic mem_valid,
	input  logic mem_write,
	input  logic mem_flush,
	input  logic mem_ready
);

	// Set by any failing assertion
	logic sva_fail = 1'b0;

	// Request issued to the memory and not yet answered
	logic in_flight;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_flight <= 1'b0;
		end
		else if (mem_valid)
		begin
			in_flight <= 1'b1;
		end
		else if (mem_ready)
		begin
			in_flight <= 1'b0;
		end
	end

	//////////////////////////////
	// Memory side
	//////////////////////////////

	// No new issue until the memory has answered
	a_issue_idle: assert property (@(posedge clk) disable iff (rst)
		mem_valid |-> !in_flight)
		else
		begin
			$error("mem_valid raised while a request was in progress");
			sva_fail = 1'b1;
		end

	a_flush_not_write: assert property (@(posedge clk) disable iff (rst)
		mem_valid |-> !(mem_write && mem_flush))
		else
		begin
			$error("flush issued as a write");
			sva_fail = 1'b1;
		end

	//////////////////////////////
	// Lane side
	//////////////////////////////

	// Ready lands once on the granted lane while its request is open
	a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
		(ready != '0) |-> ($onehot(ready) && ready[grant] && req_valid[grant] && in_flight))
		else
		begin
			$error("ready not one-hot on the granted lane");
			sva_fail = 1'b1;
		end

	for (genvar g = 0; g < LANES; g++)
	begin : g_lane_chk
		// Valid level held until its ready
		a_hold_valid: assert property (@(posedge clk) disable iff (rst)
			(req_valid[g] && !ready[g]) |=> req_valid[g])
			else
			begin
				$error("req_valid dropped before ready");
				sva_fail = 1'b1;
			end
	end

endmodule

bind mem_port_arbiter dcache_test_sva #(.LANES(LANES)) u_sva (
	.clk       (clk),
	.rst       (rst),
	.req_valid (req_valid),
	.ready     (ready),
	.grant     (grant),
	.mem_valid (mem_valid),
	.mem_write (mem_write),
	.mem_flush (mem_flush),
	.mem_ready (mem_ready)
);

//--- testbench/tb_dcache_test.sv
`include "dcache_test_params.svh"

module tb_dcache_test;

	localparam int ROWS = 8;
	localparam int PASSES_PER_ROW = 3;
	// Worst case per request times two
	localparam int TIMEOUT_CYCLES = ROWS * PASSES_PER_ROW * `DT_LANES * (2 * `DT_ROM_DEPTH + 1)
		* (`DT_MEM_LATENCY + `DT_GAP_CYCLES + 3) * 2;

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	// Inject flag, lane, pass target, cumulative fail counts
	localparam bit ROW_INJ [ROWS] = '{0, 1, 1, 0, 1, 1, 1, 0};
	localparam int ROW_LANE [ROWS] = '{0, 1, 3, 0, 0, 2, 1, 0};
	localparam int ROW_TARGET [ROWS] = '{2, 5, 8, 11, 14, 17, 20, 23};
	localparam int ROW_EXP [ROWS][`DT_LANES] = '{
		'{0, 0, 0, 0}, '{0, 1, 0, 0}, '{0, 1, 0, 1}, '{0, 1, 0, 1},
		'{1, 1, 0, 1}, '{1, 1, 1, 1}, '{1, 2, 1, 1}, '{1, 2, 1, 1}
	};

	logic clk;
	logic rst;
	logic inject_en;
	dcache_test_pkg::lane_t inject_lane;
	dcache_test_pkg::count_t pass_count [`DT_LANES];
	dcache_test_pkg::count_t fail_count [`DT_LANES];
	logic busy_any;

	int cycles = 0;
	// Lanes with one faulted read still to come
	bit injected [`DT_LANES] = '{default: 1'b0};
	dcache_test_pkg::lane_t last_lane;
	logic [`DT_LANES-1:0] prev_valid;

	dcache_test_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.inject_en   (inject_en),
		.inject_lane (inject_lane),
		.pass_count  (pass_count),
		.fail_count  (fail_count),
		.busy_any    (busy_any)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// Reference model and checks
	//////////////////////////////

	// Step 0x0101 per index with the lane in the top two bits
	function automatic dcache_test_pkg::data_t expected_word(input int lane, input int idx);
		dcache_test_pkg::data_t word;
		word = 32'hA5C3_0000 + 32'(idx) * 32'h0000_0101;
		word[31:30] = word[31:30] ^ 2'(lane);
		return word;
	endfunction

	// First requester after the previous grant
	function automatic dcache_test_pkg::lane_t next_in_rotation(input dcache_test_pkg::lane_t last,
		input logic [`DT_LANES-1:0] valid);
		dcache_test_pkg::lane_t cand;
		cand = last;
		for (int step = 0; step < `DT_LANES; step++)
		begin
			cand = cand + 1'b1;
			if (valid[cand])
			begin
				return cand;
			end
		end
		return last;
	endfunction

	function automatic int pass_spread();
		int lo;
		int hi;
		lo = 255;
		hi = 0;
		for (int l = 0; l < `DT_LANES; l++)
		begin
			lo = (int'(pass_count[l]) < lo) ? int'(pass_count[l]) : lo;
			hi = (int'(pass_count[l]) > hi) ? int'(pass_count[l]) : hi;
		end
		return hi - lo;
	endfunction

	function automatic dcache_test_pkg::count_t lowest_pass();
		dcache_test_pkg::count_t lo;
		lo = '1;
		for (int l = 0; l < `DT_LANES; l++)
		begin
			if (pass_count[l] < lo)
			begin
				lo = pass_count[l];
			end
		end
		return lo;
	endfunction

	task automatic check_count(input string name, input dcache_test_pkg::count_t exp,
		input dcache_test_pkg::count_t act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "Counter mismatch");
		end
	endtask

	task automatic check_lane(input string name, input dcache_test_pkg::lane_t exp,
		input dcache_test_pkg::lane_t act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "Grant mismatch");
		end
	endtask

	task automatic check_data(input string name, input dcache_test_pkg::data_t exp,
		input dcache_test_pkg::data_t act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "Read data mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %0b actual %0b", $time, name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "Flag mismatch");
		end
	endtask

	// Until every lane has finished the target number of passes
	task automatic wait_for_passes(input int target);
		bit done;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			done = 1'b1;
			for (int l = 0; l < `DT_LANES; l++)
			begin
				if (int'(pass_count[l]) < target)
				begin
					done = 1'b0;
				end
			end
		end
	endtask

	//////////////////////////////
	// Monitors
	//////////////////////////////

	// Grant order, read data and busy level at mid-cycle
	always @(negedge clk)
	begin
		dcache_test_pkg::lane_t exp_lane;
		dcache_test_pkg::mem_addr_t addr;
		dcache_test_pkg::data_t exp_word;
		if (rst)
		begin
			last_lane = dcache_test_pkg::lane_t'(`DT_LANES - 1);
			// No lane requests in reset
			check_flag("busy_any", 1'b0, busy_any);
		end
		else
		begin
			if (dut0.mem_valid)
			begin
				if (prev_valid == '0)
				begin
					$display("mem_valid seen with no lane requesting at %0t", $time);
					$display("Simulation FAILED");
					$fatal(1, "Spurious grant");
				end
				exp_lane = next_in_rotation(last_lane, prev_valid);
				check_lane("u_arb.grant", exp_lane, dcache_test_pkg::lane_t'(dut0.u_arb.grant));
				last_lane = exp_lane;
			end
			// Granted lane holds its request until the ready
			if (dut0.mem_valid || (dut0.ready != '0))
			begin
				check_flag("busy_any", 1'b1, busy_any);
			end
			for (int i = 0; i < `DT_LANES; i++)
			begin
				addr = dut0.req_addr[i];
				if (dut0.ready[i] && !dut0.req_write[i] && !dut0.req_flush[i])
				begin
					exp_word = expected_word(i, int'(addr[3:0]));
					// Faulted word reads back once with bit 0 flipped
					if (injected[i] && (dut0.rd_data === (exp_word ^ 32'h0000_0001)))
					begin
						exp_word = exp_word ^ 32'h0000_0001;
						injected[i] = 1'b0;
					end
					check_data($sformatf("rd_data lane %0d", i), exp_word, dut0.rd_data);
				end
			end
		end
		prev_valid = dut0.req_valid;
	end

	// Run limit and assertion watch
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: lanes did not reach their pass targets in %0d cycles", cycles);
			$display("Simulation FAILED");
			$fatal(1, "Timeout");
		end
		if (dut0.u_arb.u_sva.sva_fail)
		begin
			$display("An arbiter handshake assertion failed at %0t", $time);
			$display("Simulation FAILED");
			$fatal(1, "Assertion failure");
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		void'($urandom(70647));
		rst = 1'b1;
		inject_en = 1'b0;
		inject_lane = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		for (int r = 0; r < ROWS; r++)
		begin
			// Random offset into the pass
			repeat ($urandom_range(63, 0)) @(negedge clk);
			inject_en = ROW_INJ[r];
			inject_lane = dcache_test_pkg::lane_t'(ROW_LANE[r]);
			if (ROW_INJ[r])
			begin
				injected[ROW_LANE[r]] = 1'b1;
			end
			@(negedge clk);
			inject_en = 1'b0;

			wait_for_passes(ROW_TARGET[r]);
			// Slowest lane sits exactly on the target
			check_count("lowest pass_count", dcache_test_pkg::count_t'(ROW_TARGET[r]),
				lowest_pass());
			// Lanes stay in step
			if (pass_spread() > 1)
			begin
				$display("Lanes drifted apart by more than one pass at %0t", $time);
				$display("Simulation FAILED");
				$fatal(1, "Starvation");
			end
			for (int l = 0; l < `DT_LANES; l++)
			begin
				check_count($sformatf("fail_count[%0d]", l),
					dcache_test_pkg::count_t'(ROW_EXP[r][l]), fail_count[l]);
			end
		end

		if (!dut0.u_arb.u_sva.sva_fail)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/data_mem_model.sv
`include "dcache_test_params.svh"

module data_mem_model
(
	input  logic clk,
	input  logic rst,
	input  logic mem_valid,
	input  logic mem_write,
	input  logic mem_flush,
	input  dcache_test_pkg::mem_addr_t mem_addr,
	input  dcache_test_pkg::data_t mem_wdata,
	output logic mem_ready,
	output dcache_test_pkg::data_t mem_rdata
);

	localparam logic [3:0] LAT_LOAD = 4'(`DT_MEM_LATENCY - 1);

	// One word per address, whole address space
	dcache_test_pkg::data_t mem [2**$bits(dcache_test_pkg::mem_addr_t)];

	logic busy;
	logic [3:0] lat_cnt;
	logic rd_pend;
	dcache_test_pkg::mem_addr_t addr_q;

	//////////////////////////////
	// Latency counter
	//////////////////////////////

	// Ready lands DT_MEM_LATENCY cycles after the valid
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy      <= 1'b0;
			lat_cnt   <= '0;
			mem_ready <= 1'b0;
		end
		else
		begin
			mem_ready <= 1'b0;
			if (mem_valid && !busy)
			begin
				busy    <= 1'b1;
				lat_cnt <= LAT_LOAD;
			end
			else if (busy)
			begin
				if (lat_cnt == 4'd1)
				begin
					busy      <= 1'b0;
					mem_ready <= 1'b1;
				end
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Write on acceptance, read at completion
	// A flush touches nothing
	always_ff @(posedge clk)
	begin
		if (mem_valid && !busy)
		begin
			addr_q  <= mem_addr;
			rd_pend <= !mem_write && !mem_flush;
			if (mem_write && !mem_flush)
			begin
				mem[mem_addr] <= mem_wdata;
			end
		end
		if (busy && (lat_cnt == 4'd1) && rd_pend)
		begin
			mem_rdata <= mem[addr_q];
		end
	end

endmodule

//--- verilog/dcache_test_params.svh
`ifndef DCACHE_TEST_PARAMS_SVH
`define DCACHE_TEST_PARAMS_SVH

//////////////////////////////
// Soak tester sizing
//////////////////////////////

// Number of tester lanes sharing the memory port
`define DT_LANES 4

// Pattern words per lane, also the addresses walked per pass
`define DT_ROM_DEPTH 16

//////////////////////////////
// Timing knobs
//////////////////////////////

// Idle cycles after a ready before the lane reloads the ROM
`define DT_GAP_CYCLES 1

// Cycles from an accepted request to the ready pulse
// Model needs at least 2 here
`define DT_MEM_LATENCY 3

`endif

//--- verilog/dcache_test_pkg.sv
package dcache_test_pkg;

	//////////////////////////////
	// Tester lane and pass fields
	//////////////////////////////

	// Lane number, one per tester instance
	typedef logic [1:0] lane_t;

	// Pattern index, also the word offset inside a bank
	typedef logic [3:0] rom_index_t;

	// Bank picked by the pass number, wraps after four passes
	typedef logic [1:0] bank_t;

	//////////////////////////////
	// Memory port fields
	//////////////////////////////

	// Word address, laid out as {lane, bank, index}
	// Each lane owns a quarter of the memory
	typedef logic [7:0] mem_addr_t;

	// Data word on both the write and the read path
	typedef logic [31:0] data_t;

	//////////////////////////////
	// Status
	//////////////////////////////

	// Pass counter wraps, fail counter sticks at all ones
	typedef logic [7:0] count_t;

endpackage

//--- verilog/dcache_test_top.sv
`include "dcache_test_params.svh"

module dcache_test_top
(
	input  logic clk,
	input  logic rst,
	input  logic inject_en,
	input  dcache_test_pkg::lane_t inject_lane,
	output dcache_test_pkg::count_t pass_count [`DT_LANES],
	output dcache_test_pkg::count_t fail_count [`DT_LANES],
	output logic busy_any
);

	// ROM ports
	dcache_test_pkg::rom_index_t rom_index [`DT_LANES];
	dcache_test_pkg::data_t rom_data [`DT_LANES];

	// Lane requests
	logic [`DT_LANES-1:0] req_valid;
	logic [`DT_LANES-1:0] req_write;
	logic [`DT_LANES-1:0] req_flush;
	dcache_test_pkg::mem_addr_t req_addr [`DT_LANES];
	dcache_test_pkg::data_t req_wdata [`DT_LANES];
	logic [`DT_LANES-1:0] ready;
	dcache_test_pkg::data_t rd_data;

	// Single memory port
	logic mem_valid;
	logic mem_write;
	logic mem_flush;
	dcache_test_pkg::mem_addr_t mem_addr;
	dcache_test_pkg::data_t mem_wdata;
	logic mem_ready;
	dcache_test_pkg::data_t mem_rdata;

	//////////////////////////////
	// Pattern source
	//////////////////////////////

	pattern_rom u_rom (
		.clk       (clk),
		.rom_index (rom_index),
		.rom_data  (rom_data)
	);

	//////////////////////////////
	// Tester lanes
	//////////////////////////////

	for (genvar g = 0; g < `DT_LANES; g++)
	begin : g_lane
		mem_tester #(.LANE(g)) u_lane (
			.clk        (clk),
			.rst        (rst),
			.rom_index  (rom_index[g]),
			.rom_data   (rom_data[g]),
			// Fault pulse steered to one lane
			.inject     (inject_en && (inject_lane == dcache_test_pkg::lane_t'(g))),
			.req_valid  (req_valid[g]),
			.req_write  (req_write[g]),
			.req_flush  (req_flush[g]),
			.req_addr   (req_addr[g]),
			.req_wdata  (req_wdata[g]),
			.ready      (ready[g]),
			.rd_data    (rd_data),
			.pass_count (pass_count[g]),
			.fail_count (fail_count[g])
		);
	end

	//////////////////////////////
	// Shared port and memory
	//////////////////////////////

	mem_port_arbiter #(.LANES(`DT_LANES)) u_arb (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_flush (req_flush),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.ready     (ready),
		.rd_data   (rd_data),
		.mem_valid (mem_valid),
		.mem_write (mem_write),
		.mem_flush (mem_flush),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

	data_mem_model u_mem (
		.clk       (clk),
		.rst       (rst),
		.mem_valid (mem_valid),
		.mem_write (mem_write),
		.mem_flush (mem_flush),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

	// Any lane with a request outstanding
	assign busy_any = |req_valid;

endmodule

//--- verilog/mem_port_arbiter.sv
module mem_port_arbiter #(
	parameter int LANES = 4
)
(
	input  logic clk,
	input  logic rst,
	input  logic [LANES-1:0] req_valid,
	input  logic [LANES-1:0] req_write,
	input  logic [LANES-1:0] req_flush,
	input  dcache_test_pkg::mem_addr_t req_addr [LANES],
	input  dcache_test_pkg::data_t req_wdata [LANES],
	output logic [LANES-1:0] ready,
	output dcache_test_pkg::data_t rd_data,
	output logic mem_valid,
	output logic mem_write,
	output logic mem_flush,
	output dcache_test_pkg::mem_addr_t mem_addr,
	output dcache_test_pkg::data_t mem_wdata,
	input  logic mem_ready,
	input  dcache_test_pkg::data_t mem_rdata
);

	localparam int IW = $clog2(LANES);

	logic busy;
	logic [IW-1:0] grant;
	logic [IW-1:0] last_grant;
	logic [IW-1:0] pick;
	logic any_valid;

	assign any_valid = |req_valid;

	//////////////////////////////
	// Round-robin search
	//////////////////////////////

	// First valid lane after the last grant, wrapping around
	always_comb
	begin
		int cand;
		logic found;
		pick  = last_grant;
		found = 1'b0;
		for (int i = 1; i <= LANES; i++)
		begin
			cand = (int'(last_grant) + i) % LANES;
			if (!found && req_valid[cand])
			begin
				pick  = IW'(cand);
				found = 1'b1;
			end
		end
	end

	// Grant held until the memory answers
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy       <= 1'b0;
			grant      <= '0;
			last_grant <= IW'(LANES - 1);
			mem_valid  <= 1'b0;
		end
		else
		begin
			mem_valid <= 1'b0;
			if (!busy && any_valid)
			begin
				busy      <= 1'b1;
				grant     <= pick;
				mem_valid <= 1'b1;
			end
			else if (busy && mem_ready)
			begin
				busy       <= 1'b0;
				last_grant <= grant;
			end
		end
	end

	// Request fields captured with the grant
	always_ff @(posedge clk)
	begin
		if (!busy && any_valid)
		begin
			mem_write <= req_write[pick];
			mem_flush <= req_flush[pick];
			mem_addr  <= req_addr[pick];
			mem_wdata <= req_wdata[pick];
		end
	end

	//////////////////////////////
	// Return path
	//////////////////////////////

	// Ready goes to the granted lane only
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
		begin
			ready[i] = mem_ready && busy && (grant == IW'(i));
		end
	end

	// Shared read bus, lanes qualify it with their ready
	assign rd_data = mem_rdata;

endmodule

//--- verilog/mem_tester.sv
`include "dcache_test_params.svh"

module mem_tester #(
	parameter int LANE = 0
)
(
	input  logic clk,
	input  logic rst,
	output dcache_test_pkg::rom_index_t rom_index,
	input  dcache_test_pkg::data_t rom_data,
	input  logic inject,
	output logic req_valid,
	output logic req_write,
	output logic req_flush,
	output dcache_test_pkg::mem_addr_t req_addr,
	output dcache_test_pkg::data_t req_wdata,
	input  logic ready,
	input  dcache_test_pkg::data_t rd_data,
	output dcache_test_pkg::count_t pass_count,
	output dcache_test_pkg::count_t fail_count
);

	// Sequencer states, GAP is shared by every kind of request
	typedef enum logic [2:0] {
		ST_WAIT_ROM,
		ST_WRITE,
		ST_READ,
		ST_FLUSH,
		ST_GAP
	} state_t;

	// Request to issue once the ROM wait is over
	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_FLUSH
	} op_t;

	localparam logic [7:0] GAP_LAST = 8'(`DT_GAP_CYCLES - 1);
	localparam dcache_test_pkg::rom_index_t LAST_INDEX =
		dcache_test_pkg::rom_index_t'(`DT_ROM_DEPTH - 1);

	state_t state;
	op_t next_op;
	dcache_test_pkg::rom_index_t index;
	dcache_test_pkg::bank_t bank;
	logic [7:0] gap_cnt;
	logic inject_armed;
	logic corrupt_now;
	logic mismatch;

	// Clean pattern for the compare, and the word actually sent
	dcache_test_pkg::data_t pattern;
	dcache_test_pkg::data_t wdata_q;

	//////////////////////////////
	// Request outputs
	//////////////////////////////

	assign rom_index = index;
	assign req_valid = (state == ST_WRITE) || (state == ST_READ) || (state == ST_FLUSH);
	assign req_write = (state == ST_WRITE);
	assign req_flush = (state == ST_FLUSH);
	// Lane picks its quarter, bank steps per pass
	assign req_addr  = {dcache_test_pkg::lane_t'(LANE), bank, index};
	assign req_wdata = wdata_q;

	// Armed fault hits only the next write
	assign corrupt_now = (state == ST_WAIT_ROM) && (next_op == OP_WRITE) && inject_armed;
	assign mismatch    = (rd_data != pattern);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= ST_WAIT_ROM;
			next_op <= OP_WRITE;
			index   <= '0;
			bank    <= '0;
			gap_cnt <= '0;
		end
		else
		begin
			case (state)
				// ROM data for the current index is stable here
				ST_WAIT_ROM:
				begin
					case (next_op)
						OP_WRITE: state <= ST_WRITE;
						OP_READ:  state <= ST_READ;
						default:  state <= ST_FLUSH;
					endcase
				end
				// Valid held until ready, then read the same word back
				ST_WRITE:
				begin
					if (ready)
					begin
						next_op <= OP_READ;
						gap_cnt <= '0;
						state   <= ST_GAP;
					end
				end
				ST_READ:
				begin
					if (ready)
					begin
						// End of the block, flush before the next pass
						if (index == LAST_INDEX)
						begin
							next_op <= OP_FLUSH;
						end
						else
						begin
							next_op <= OP_WRITE;
							index   <= index + 1'b1;
						end
						gap_cnt <= '0;
						state   <= ST_GAP;
					end
				end
				// Flush ack closes the pass
				ST_FLUSH:
				begin
					if (ready)
					begin
						next_op <= OP_WRITE;
						index   <= '0;
						bank    <= bank + 1'b1;
						gap_cnt <= '0;
						state   <= ST_GAP;
					end
				end
				ST_GAP:
				begin
					if (gap_cnt == GAP_LAST)
					begin
						state <= ST_WAIT_ROM;
					end
					else
					begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= ST_WAIT_ROM;
				end
			endcase
		end
	end

	// Fault one-shot, a new pulse wins over the clear
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			inject_armed <= 1'b0;
		end
		else
		begin
			if (corrupt_now)
			begin
				inject_armed <= 1'b0;
			end
			if (inject)
			begin
				inject_armed <= 1'b1;
			end
		end
	end

	// Latch the word at the end of the ROM wait
	always_ff @(posedge clk)
	begin
		if (state == ST_WAIT_ROM)
		begin
			pattern <= rom_data;
			wdata_q <= corrupt_now ? (rom_data ^ 32'h0000_0001) : rom_data;
		end
	end

	//////////////////////////////
	// Counters
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pass_count <= '0;
			fail_count <= '0;
		end
		else
		begin
			if ((state == ST_FLUSH) && ready)
			begin
				pass_count <= pass_count + 1'b1;
			end
			// Saturate so a stuck lane stays visible
			if ((state == ST_READ) && ready && mismatch && (fail_count != '1))
			begin
				fail_count <= fail_count + 1'b1;
			end
		end
	end

endmodule

//--- verilog/pattern_rom.sv
`include "dcache_test_params.svh"

module pattern_rom
(
	input  logic clk,
	input  dcache_test_pkg::rom_index_t rom_index [`DT_LANES],
	output dcache_test_pkg::data_t rom_data [`DT_LANES]
);

	// Lane pattern table, constant after elaboration
	dcache_test_pkg::data_t pat_table [`DT_LANES][`DT_ROM_DEPTH];

	//////////////////////////////
	// Pattern rule
	//////////////////////////////

	// Base word stepped by 0x0101 per index
	// Lane number lands in the top two bits
	function automatic dcache_test_pkg::data_t pattern_word(input int lane, input int idx);
		dcache_test_pkg::data_t base;
		dcache_test_pkg::data_t lane_bits;
		base = 32'hA5C3_0000 + (32'(idx) * 32'h0000_0101);
		lane_bits = {2'(lane), 30'd0};
		return base ^ lane_bits;
	endfunction

	// Fill the table from the rule
	always_comb
	begin
		for (int l = 0; l < `DT_LANES; l++)
		begin
			for (int i = 0; i < `DT_ROM_DEPTH; i++)
			begin
				pat_table[l][i] = pattern_word(l, i);
			end
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// One registered read per lane, one cycle index to data
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < `DT_LANES; l++)
		begin
			rom_data[l] <= pat_table[l][rom_index[l]];
		end
	end

endmodule
